//--- lenet_c1.f
+incdir+include
hdl/lenet_c1_pkg.sv
hdl/c1_weight_regs.sv
hdl/frame_position_counter.sv
hdl/c1_sequencer.sv
hdl/line_buffer.sv
hdl/conv55_mac.sv
hdl/maxpool22.sv
hdl/lenet_c1_top.sv
sim/c1_ref_model_pkg.sv
sim/lenet_c1_tb.sv

//--- sim/lenet_c1_tb.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module lenet_c1_tb;

	import c1_ref_model_pkg::*;

	localparam int FRAME_PIX = `IMAGE_ROWS * `IMAGE_COLS;
	localparam int POOL_PER_FRAME = `S2_SIZE * `S2_SIZE;
	// five frames at up to three cycles a pixel plus register traffic
	localparam int CYCLE_LIMIT = 5 * FRAME_PIX * 3 + 2000;
	localparam int OKAY = 0;
	localparam int SLVERR = 2;

	logic clk;
	logic rst_n;
	logic [`AXI_AW-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [`AXI_DW-1:0] s_axi_wdata;
	logic [`AXI_DW/8-1:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [`AXI_AW-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [`AXI_DW-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic pixel_valid;
	lenet_c1_pkg::pixel_t pixel_data;
	logic pixel_ready;
	logic pool_valid;
	lenet_c1_pkg::conv_t pool_data;

	string test_name = "reset";
	int cyc = 0;
	int pix_idx = 0;
	int out_cnt = 0;
	int val_errs = 0;
	int other_errs = 0;
	int exp_v;
	// cycle at which each pool output is due
	int due_q [$];

	lenet_c1_top uut (
		.clk(clk), .rst_n(rst_n),
		.s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready), .s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.pixel_valid(pixel_valid), .pixel_data(pixel_data), .pixel_ready(pixel_ready),
		.pool_valid(pool_valid), .pool_data(pool_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// cycle count, pixel positions and output checks
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: run passed %0d cycles in test %s", CYCLE_LIMIT, test_name);
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			if (pixel_valid && pixel_ready) begin
				// odd C1 row and col is odd image row and col past the border
				if (pix_idx / `IMAGE_COLS >= `KERNEL - 1 && pix_idx % `IMAGE_COLS >= `KERNEL - 1
						&& (pix_idx / `IMAGE_COLS) % 2 == 1 && (pix_idx % `IMAGE_COLS) % 2 == 1)
					due_q.push_back(cyc + 3);
				pix_idx = (pix_idx + 1) % FRAME_PIX;
			end
			if (pool_valid) begin
				if (due_q.size() == 0 || due_q[0] != cyc) begin
					other_errs++;
					$display("pool_valid came at the wrong cycle in test %s", test_name);
				end else begin
					void'(due_q.pop_front());
				end
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("more outputs than expected in test %s", test_name);
				end else begin
					exp_v = exp_q.pop_front();
					if (int'(pool_data) != exp_v) begin
						val_errs++;
						$display("Error %s: pool_data expected %0d, actual %0d",
							test_name, exp_v, int'(pool_data));
					end
				end
				out_cnt++;
			end else if (due_q.size() > 0 && due_q[0] == cyc) begin
				other_errs++;
				$display("pool_valid missing at its cycle in test %s", test_name);
				void'(due_q.pop_front());
			end
		end
	end

	task automatic check_value(input string what, input int exp, input int act);
		if (exp != act) begin
			val_errs++;
			$display("Error %s: %s expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// aw and w offered together, then wait for b
	task automatic axi_write(input logic [`AXI_AW-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		s_axi_awaddr <= addr;
		s_axi_wdata <= data;
		s_axi_wstrb <= 4'hf;
		s_axi_awvalid <= 1'b1;
		s_axi_wvalid <= 1'b1;
		@(posedge clk);
		while (!(s_axi_awready && s_axi_wready))
			@(posedge clk);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		s_axi_bready <= 1'b1;
		@(posedge clk);
		while (!s_axi_bvalid)
			@(posedge clk);
		resp = s_axi_bresp;
		s_axi_bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`AXI_AW-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		@(posedge clk);
		while (!s_axi_arready)
			@(posedge clk);
		s_axi_arvalid <= 1'b0;
		s_axi_rready <= 1'b1;
		@(posedge clk);
		while (!s_axi_rvalid)
			@(posedge clk);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		s_axi_rready <= 1'b0;
	endtask

	task automatic write_coeffs();
		logic [1:0] resp;
		for (int i = 0; i < `KERNEL * `KERNEL; i++) begin
			axi_write(8'(`REG_WEIGHT0 + 4 * i), 32'(wt[i]), resp);
			check_value("weight write resp", OKAY, int'(resp));
		end
		axi_write(`REG_BIAS, 32'(bias_v), resp);
		check_value("bias write resp", OKAY, int'(resp));
	endtask

	// stall inserts idle beats on roughly a quarter of the cycles
	task automatic send_frame(input bit stall);
		int i;
		i = 0;
		while (i < FRAME_PIX) begin
			if (stall && rand_bits(2) == 0) begin
				pixel_valid <= 1'b0;
			end else begin
				pixel_valid <= 1'b1;
				pixel_data <= lenet_c1_pkg::pixel_t'(img[i]);
			end
			@(posedge clk);
			if (pixel_valid && pixel_ready)
				i++;
		end
		pixel_valid <= 1'b0;
	endtask

	task automatic wait_frame_done();
		logic [1:0] resp;
		logic [31:0] data;
		data = '0;
		while (data[1] == 1'b0)
			axi_read(`REG_STATUS, data, resp);
		check_value("busy after frame", 0, int'(data[0]));
	endtask

	// poke tries a weight write while the frame runs
	task automatic run_frame(input bit stall, input bit poke);
		logic [1:0] resp;
		logic [1:0] poke_resp;
		build_expected();
		out_cnt = 0;
		axi_write(`REG_CTRL, 32'd1, resp);
		check_value("start resp", OKAY, int'(resp));
		fork
			send_frame(stall);
			begin
				if (poke) begin
					repeat (200) @(posedge clk);
					axi_write(`REG_WEIGHT0, 32'(wt[0] + 1), poke_resp);
					check_value("busy write resp", SLVERR, int'(poke_resp));
				end
			end
		join
		wait_frame_done();
		check_value("outputs per frame", POOL_PER_FRAME, out_cnt);
		check_value("outputs left over", 0, exp_q.size());
	endtask

	// weights span lo to lo + 2^bits - 1
	function automatic void random_coeffs(int bits);
		for (int i = 0; i < `KERNEL * `KERNEL; i++)
			wt[i] = rand_bits(bits) - (1 << (bits - 1));
		bias_v = rand_bits(8) - 128;
	endfunction

	function automatic void random_image();
		for (int i = 0; i < FRAME_PIX; i++)
			img[i] = rand_bits(8) - 128;
	endfunction

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		s_axi_awaddr <= '0;
		s_axi_awvalid <= 1'b0;
		s_axi_wdata <= '0;
		s_axi_wstrb <= '0;
		s_axi_wvalid <= 1'b0;
		s_axi_bready <= 1'b0;
		s_axi_araddr <= '0;
		s_axi_arvalid <= 1'b0;
		s_axi_rready <= 1'b0;
		pixel_valid <= 1'b0;
		pixel_data <= '0;
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// outputs idle and registers cleared
		check_value("pixel_ready", 0, int'(pixel_ready));
		check_value("pool_valid", 0, int'(pool_valid));
		check_value("bvalid", 0, int'(s_axi_bvalid));
		check_value("rvalid", 0, int'(s_axi_rvalid));
		for (int i = 0; i < `KERNEL * `KERNEL; i++) begin
			axi_read(8'(`REG_WEIGHT0 + 4 * i), data, resp);
			check_value("weight after reset", 0, int'(data));
		end
		axi_read(`REG_BIAS, data, resp);
		check_value("bias after reset", 0, int'(data));
		axi_read(`REG_STATUS, data, resp);
		check_value("status after reset", 0, int'(data));

		// full-range coefficients read back sign-extended
		test_name = "readback";
		random_coeffs(8);
		write_coeffs();
		for (int i = 0; i < `KERNEL * `KERNEL; i++) begin
			axi_read(8'(`REG_WEIGHT0 + 4 * i), data, resp);
			check_value("weight readback", wt[i], int'(data));
			check_value("weight read resp", OKAY, int'(resp));
		end
		axi_read(`REG_BIAS, data, resp);
		check_value("bias readback", bias_v, int'(data));
		axi_read(8'h70, data, resp);
		check_value("unmapped read resp", SLVERR, int'(resp));
		axi_write(8'h90, 32'd0, resp);
		check_value("unmapped write resp", SLVERR, int'(resp));

		// small weights keep most sums inside 16 bits
		test_name = "random_frame";
		random_coeffs(5);
		write_coeffs();
		random_image();
		run_frame(1'b0, 1'b0);

		test_name = "stalled_stream";
		random_image();
		run_frame(1'b1, 1'b0);

		test_name = "write_in_frame";
		random_coeffs(5);
		write_coeffs();
		random_image();
		run_frame(1'b0, 1'b1);
		axi_read(`REG_WEIGHT0, data, resp);
		check_value("weight 0 after rejected write", wt[0], int'(data));

		// all sums far above the 16-bit range
		test_name = "saturation";
		for (int i = 0; i < `KERNEL * `KERNEL; i++)
			wt[i] = 127;
		bias_v = 127;
		write_coeffs();
		for (int i = 0; i < FRAME_PIX; i++)
			img[i] = 127;
		run_frame(1'b0, 1'b0);

		// every sum negative
		test_name = "relu";
		bias_v = -128;
		write_coeffs();
		for (int i = 0; i < FRAME_PIX; i++)
			img[i] = -128;
		run_frame(1'b0, 1'b0);

		$display("value errors: %0d, other errors: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim/c1_ref_model_pkg.sv
`include "lenet_c1_config.svh"

package c1_ref_model_pkg;

	// generator state, shared by all stimulus
	logic [31:0] lfsr_state = 32'h4bfe_7f11;

	// frame and coefficients the model works on
	int img [`IMAGE_ROWS*`IMAGE_COLS];
	int wt [`KERNEL*`KERNEL];
	int bias_v;

	// expected S2 outputs, raster order
	int exp_q [$];

	// fibonacci form, taps 32 22 2 1
	// one shift for every bit handed out
	function automatic int rand_bits(int n);
		int v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	// one C1 value at map position cr, cc
	// kernel row 0 sits on the oldest image row
	function automatic int conv_at(int cr, int cc);
		int acc;
		acc = bias_v;
		for (int r = 0; r < `KERNEL; r++)
			for (int c = 0; c < `KERNEL; c++)
				acc += img[(cr + r) * `IMAGE_COLS + cc + c] * wt[r * `KERNEL + c];
		// clamp to 16 bits signed
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		// relu
		return (acc < 0) ? 0 : acc;
	endfunction

	// max over one 2x2 block of the C1 map
	function automatic int pool_at(int pr, int pc);
		int m;
		int v;
		m = conv_at(2 * pr, 2 * pc);
		for (int k = 1; k < 4; k++) begin
			v = conv_at(2 * pr + k / 2, 2 * pc + k % 2);
			if (v > m)
				m = v;
		end
		return m;
	endfunction

	// whole S2 map for the current frame
	function automatic void build_expected();
		exp_q.delete();
		for (int pr = 0; pr < `S2_SIZE; pr++)
			for (int pc = 0; pc < `S2_SIZE; pc++)
				exp_q.push_back(pool_at(pr, pc));
	endfunction

endpackage

//--- hdl/lenet_c1_top.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module lenet_c1_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`AXI_AW-1:0]    s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic [`AXI_DW-1:0]    s_axi_wdata,
	input  logic [`AXI_DW/8-1:0]  s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [`AXI_AW-1:0]    s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic [`AXI_DW-1:0]    s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	input  logic                  pixel_valid,
	input  lenet_c1_pkg::pixel_t  pixel_data,
	output logic                  pixel_ready,
	output logic                  pool_valid,
	output lenet_c1_pkg::conv_t   pool_data
);

	// coefficients
	logic [`KERNEL*`KERNEL*`PIX_W-1:0] kernel;
	logic signed [`PIX_W-1:0] bias;
	// control
	logic start_frame, busy, frame_done;
	logic pix_accept, conv_fire, pool_fire, last_pixel;
	logic [$clog2(`IMAGE_ROWS)-1:0] row;
	logic [$clog2(`IMAGE_COLS)-1:0] col;
	// datapath
	logic [(`KERNEL-1)*`PIX_W-1:0] row_taps;
	logic conv_valid;
	logic signed [`HALF_W-1:0] conv_data;
	logic signed [`HALF_W-1:0] prev_row;

	c1_weight_regs u_regs (.clk, .rst_n,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready, .s_axi_wdata, .s_axi_wstrb,
		.s_axi_wvalid, .s_axi_wready, .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready, .s_axi_rdata, .s_axi_rresp,
		.s_axi_rvalid, .s_axi_rready,
		.busy, .frame_done, .start_frame, .kernel, .bias);

	c1_sequencer u_seq (.clk, .rst_n, .start_frame, .pixel_valid, .row, .col, .last_pixel,
		.pixel_ready, .pix_accept, .conv_fire, .pool_fire, .busy, .frame_done);

	frame_position_counter u_pos (.clk, .rst_n, .pix_accept, .start_frame,
		.row, .col, .last_pixel);

	// four previous image rows
	line_buffer #(.payload_t(logic signed [`PIX_W-1:0]), .DEPTH(`IMAGE_COLS),
		.TAPS(`KERNEL-1)) u_in_rows (.clk, .rst_n, .shift_en(pix_accept),
		.din(pixel_data), .taps(row_taps));

	conv55_mac u_mac (.clk, .rst_n, .pix_accept, .conv_fire, .pixel_data, .row_taps,
		.kernel, .bias, .conv_valid, .conv_data);

	// previous C1 row, advanced once per conv result
	line_buffer #(.payload_t(logic signed [`HALF_W-1:0]), .DEPTH(`C1_SIZE),
		.TAPS(1)) u_conv_row (.clk, .rst_n, .shift_en(conv_valid),
		.din(conv_data), .taps(prev_row));

	maxpool22 u_pool (.clk, .rst_n, .conv_valid, .conv_data, .prev_row, .pool_fire,
		.pool_valid, .pool_data);

endmodule

//--- hdl/maxpool22.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module maxpool22 (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  conv_valid,
	input  lenet_c1_pkg::conv_t   conv_data,
	input  lenet_c1_pkg::conv_t   prev_row,
	input  logic                  pool_fire,
	output logic                  pool_valid,
	output lenet_c1_pkg::conv_t   pool_data
);

	import lenet_c1_pkg::*;

	// left column of the 2x2 block
	conv_t left_top;
	conv_t left_bot;
	conv_t max_top;
	conv_t max_bot;

	function automatic conv_t max2(conv_t a, conv_t b);
		return (a > b) ? a : b;
	endfunction

	assign max_top = max2(left_top, prev_row);
	assign max_bot = max2(left_bot, conv_data);

	// every conv result becomes the left pair for the next one
	always_ff @(posedge clk) begin
		if (conv_valid) begin
			left_top <= prev_row;
			left_bot <= conv_data;
		end
		if (pool_fire)
			pool_data <= max2(max_top, max_bot);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pool_valid <= 1'b0;
		else
			pool_valid <= pool_fire;
	end

	// pool_fire must line up with a conv result
	assert property (@(posedge clk) disable iff (!rst_n)
		pool_valid |-> $past(pool_fire && conv_valid));

endmodule

//--- hdl/conv55_mac.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module conv55_mac (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      pix_accept,
	input  logic                      conv_fire,
	input  lenet_c1_pkg::pixel_t      pixel_data,
	input  lenet_c1_pkg::row_taps_t   row_taps,
	input  lenet_c1_pkg::kernel_t     kernel,
	input  lenet_c1_pkg::pixel_t      bias,
	output logic                      conv_valid,
	output lenet_c1_pkg::conv_t       conv_data
);

	import lenet_c1_pkg::*;

	localparam int K = `KERNEL;
	localparam acc_t SAT_MAX = acc_t'(32'sd32767);
	localparam acc_t SAT_MIN = -acc_t'(32'sd32768);

	// four stored columns, col 0 oldest
	pixel_t win [K][K-1];
	// newest column comes straight from the line buffer taps
	pixel_t col_now [K];
	acc_t sum_c;
	acc_t acc_q;
	acc_t biased;
	conv_t sat;
	logic v1;

	// kernel row 0 is the oldest image row
	always_comb begin
		for (int r = 0; r < K - 1; r++)
			col_now[r] = row_taps[K-2-r];
		col_now[K-1] = pixel_data;
	end

	// window shifts left by one column per accepted pixel
	always_ff @(posedge clk) begin
		if (pix_accept) begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 2; c++)
					win[r][c] <= win[r][c+1];
				win[r][K-2] <= col_now[r];
			end
		end
	end

	// stage 1 products, window plus the live column
	always_comb begin
		sum_c = '0;
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K; c++) begin
				if (c < K - 1)
					sum_c = sum_c + acc_t'(win[r][c]) * acc_t'(kernel[r*K+c]);
				else
					sum_c = sum_c + acc_t'(col_now[r]) * acc_t'(kernel[r*K+c]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_fire)
			acc_q <= sum_c;
	end

	// stage 2 bias, clamp to 16 bits, then ReLU
	assign biased = acc_q + acc_t'(bias);

	always_comb begin
		if (biased > SAT_MAX)
			sat = conv_t'(SAT_MAX);
		else if (biased < SAT_MIN)
			sat = conv_t'(SAT_MIN);
		else
			sat = conv_t'(biased);
	end

	always_ff @(posedge clk) begin
		if (v1)
			conv_data <= sat[`HALF_W-1] ? '0 : sat;
	end

	// valid follows conv_fire by two cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			conv_valid <= 1'b0;
		end else begin
			v1 <= conv_fire;
			conv_valid <= v1;
		end
	end

endmodule

//--- hdl/line_buffer.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module line_buffer #(
	parameter type payload_t = lenet_c1_pkg::pixel_t,
	parameter int  DEPTH     = `IMAGE_COLS,
	parameter int  TAPS      = `KERNEL - 1
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    shift_en,
	input  payload_t                din,
	output payload_t [TAPS-1:0]     taps
);

	localparam int LEN = DEPTH * TAPS;

	// one long shift chain, TAPS rows of DEPTH entries
	payload_t chain [LEN];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < LEN; i++)
				chain[i] <= '0;
		end else if (shift_en) begin
			chain[0] <= din;
			for (int i = 1; i < LEN; i++)
				chain[i] <= chain[i-1];
		end
	end

	// tap t is the same column, t+1 rows back
	for (genvar t = 0; t < TAPS; t++) begin : g_tap
		assign taps[t] = chain[(t+1)*DEPTH-1];
	end

endmodule

//--- hdl/c1_sequencer.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module c1_sequencer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start_frame,
	input  logic                           pixel_valid,
	input  logic [$clog2(`IMAGE_ROWS)-1:0] row,
	input  logic [$clog2(`IMAGE_COLS)-1:0] col,
	input  logic                           last_pixel,
	output logic                           pixel_ready,
	output logic                           pix_accept,
	output logic                           conv_fire,
	output logic                           pool_fire,
	output logic                           busy,
	output logic                           frame_done
);

	import lenet_c1_pkg::*;

	// cycles from last pixel until its pool result has left the pipe
	localparam logic [1:0] FLUSH_LAST = 2'd2;

	seq_state_t state;
	logic [1:0] flush_cnt;
	logic pool_hit;
	logic pool_d1;

	// only back-pressure on the stream
	assign pixel_ready = (state == S_STREAM);
	assign pix_accept = pixel_valid && pixel_ready;
	assign busy = (state != S_IDLE);

	// full 5x5 window once four rows and four cols are behind us
	assign conv_fire = pix_accept && (row >= `KERNEL - 1) && (col >= `KERNEL - 1);

	// odd C1 row and col share the parity of image row and col
	assign pool_hit = conv_fire && row[0] && col[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			flush_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_frame) begin
						state <= S_STREAM;
						frame_done <= 1'b0;
					end
				end
				S_STREAM: begin
					if (last_pixel) begin
						state <= S_FLUSH;
						flush_cnt <= '0;
					end
				end
				S_FLUSH: begin
					// three cycles, then report done
					if (flush_cnt == FLUSH_LAST) begin
						state <= S_IDLE;
						frame_done <= 1'b1;
					end else begin
						flush_cnt <= flush_cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// two stages to match the MAC latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pool_d1 <= 1'b0;
			pool_fire <= 1'b0;
		end else begin
			pool_d1 <= pool_hit;
			pool_fire <= pool_d1;
		end
	end

	// done shows up after three flush cycles behind the last pixel
	assert property (@(posedge clk) disable iff (!rst_n)
		last_pixel |-> ##4 (state == S_IDLE && frame_done));

endmodule

//--- hdl/frame_position_counter.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module frame_position_counter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           pix_accept,
	input  logic                           start_frame,
	output logic [$clog2(`IMAGE_ROWS)-1:0] row,
	output logic [$clog2(`IMAGE_COLS)-1:0] col,
	output logic                           last_pixel
);

	localparam int RW = $clog2(`IMAGE_ROWS);
	localparam int CW = $clog2(`IMAGE_COLS);
	localparam logic [RW-1:0] LAST_ROW = RW'(`IMAGE_ROWS - 1);
	localparam logic [CW-1:0] LAST_COL = CW'(`IMAGE_COLS - 1);

	// row and col point at the pixel being offered now
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= '0;
			col <= '0;
		end else if (start_frame) begin
			row <= '0;
			col <= '0;
		end else if (pix_accept) begin
			if (col == LAST_COL) begin
				col <= '0;
				// wraps to the origin after the final pixel
				row <= (row == LAST_ROW) ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// bottom-right pixel of the frame accepted this cycle
	assign last_pixel = pix_accept && (row == LAST_ROW) && (col == LAST_COL);

	// row moves only at the end of a line or on a new frame
	assert property (@(posedge clk) disable iff (!rst_n)
		!(pix_accept && col == LAST_COL) && !start_frame |=> $stable(row));

endmodule

//--- hdl/c1_weight_regs.sv
`timescale 1ns/1ps
`include "lenet_c1_config.svh"

module c1_weight_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`AXI_AW-1:0]      s_axi_awaddr,
	input  logic                    s_axi_awvalid,
	output logic                    s_axi_awready,
	input  logic [`AXI_DW-1:0]      s_axi_wdata,
	input  logic [`AXI_DW/8-1:0]    s_axi_wstrb,
	input  logic                    s_axi_wvalid,
	output logic                    s_axi_wready,
	output logic [1:0]              s_axi_bresp,
	output logic                    s_axi_bvalid,
	input  logic                    s_axi_bready,
	input  logic [`AXI_AW-1:0]      s_axi_araddr,
	input  logic                    s_axi_arvalid,
	output logic                    s_axi_arready,
	output logic [`AXI_DW-1:0]      s_axi_rdata,
	output logic [1:0]              s_axi_rresp,
	output logic                    s_axi_rvalid,
	input  logic                    s_axi_rready,
	input  logic                    busy,
	input  logic                    frame_done,
	output logic                    start_frame,
	output lenet_c1_pkg::kernel_t   kernel,
	output lenet_c1_pkg::pixel_t    bias
);

	localparam int N_TAPS = `KERNEL * `KERNEL;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic [`AXI_AW-3:0] wr_word;
	logic [`AXI_AW-3:0] rd_word;
	logic wr_go;
	logic rd_go;
	logic wr_weight, wr_bias, wr_ctrl, wr_err;
	logic [`AXI_DW-1:0] rd_val;
	logic rd_err;

	// word index into the map
	assign wr_word = s_axi_awaddr[`AXI_AW-1:2];
	assign rd_word = s_axi_araddr[`AXI_AW-1:2];

	// aw and w taken together, one write in flight
	assign wr_go = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
	assign s_axi_awready = wr_go;
	assign s_axi_wready = wr_go;

	// one read in flight
	assign s_axi_arready = !s_axi_rvalid;
	assign rd_go = s_axi_arvalid && s_axi_arready;

	// write decode
	always_comb begin
		wr_weight = 1'b0;
		wr_bias = 1'b0;
		wr_ctrl = 1'b0;
		wr_err = 1'b0;
		if (s_axi_awaddr[1:0] != 2'b00)
			wr_err = 1'b1;
		else if (wr_word < N_TAPS)
			wr_weight = 1'b1;
		else if (s_axi_awaddr == `REG_BIAS)
			wr_bias = 1'b1;
		else if (s_axi_awaddr == `REG_CTRL)
			wr_ctrl = 1'b1;
		else if (s_axi_awaddr != `REG_STATUS)
			wr_err = 1'b1;
		// coefficients are frozen while a frame runs
		if ((wr_weight || wr_bias) && busy)
			wr_err = 1'b1;
	end

	// read mux, signed registers read back sign-extended
	always_comb begin
		rd_val = '0;
		rd_err = 1'b0;
		if (s_axi_araddr[1:0] != 2'b00)
			rd_err = 1'b1;
		else if (rd_word < N_TAPS)
			rd_val = `AXI_DW'(kernel[rd_word]);
		else if (s_axi_araddr == `REG_BIAS)
			rd_val = `AXI_DW'(bias);
		else if (s_axi_araddr == `REG_STATUS)
			rd_val = {{(`AXI_DW-2){1'b0}}, frame_done, busy};
		else if (s_axi_araddr != `REG_CTRL)
			rd_err = 1'b1;
	end

	// write side and start pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kernel <= '0;
			bias <= '0;
			start_frame <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_bresp <= RESP_OKAY;
		end else begin
			start_frame <= 1'b0;
			if (s_axi_bvalid && s_axi_bready)
				s_axi_bvalid <= 1'b0;
			if (wr_go) begin
				s_axi_bvalid <= 1'b1;
				s_axi_bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
				if (!wr_err && s_axi_wstrb[0]) begin
					if (wr_weight)
						kernel[wr_word] <= s_axi_wdata[`PIX_W-1:0];
					if (wr_bias)
						bias <= s_axi_wdata[`PIX_W-1:0];
					// start only takes effect when idle
					if (wr_ctrl)
						start_frame <= s_axi_wdata[0] && !busy;
				end
			end
		end
	end

	// read response handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axi_rvalid <= 1'b0;
			s_axi_rresp <= RESP_OKAY;
		end else if (rd_go) begin
			s_axi_rvalid <= 1'b1;
			s_axi_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	// read data, captured with the address
	always_ff @(posedge clk) begin
		if (rd_go)
			s_axi_rdata <= rd_val;
	end

	// write response is held, unchanged, until the master takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

endmodule

//--- hdl/lenet_c1_pkg.sv
`include "lenet_c1_config.svh"

package lenet_c1_pkg;

	// pixels, weights and bias share one signed byte format
	typedef logic signed [`PIX_W-1:0] pixel_t;

	// conv output after saturation
	typedef logic signed [`HALF_W-1:0] conv_t;

	// wide enough for 25 full-scale byte products
	typedef logic signed [`ACC_W-1:0] acc_t;

	// 5x5 kernel, row-major
	// index 0 is row 0 col 0, row 0 is the oldest image row
	typedef pixel_t [`KERNEL*`KERNEL-1:0] kernel_t;

	// older image rows from the input line buffer
	// tap 0 is one row back, tap 3 is four rows back
	typedef pixel_t [`KERNEL-2:0] row_taps_t;

	// frame sequencer states
	typedef enum logic [1:0] {
		S_IDLE,
		S_STREAM,
		S_FLUSH
	} seq_state_t;

endpackage

//--- include/lenet_c1_config.svh
`ifndef LENET_C1_CONFIG_SVH
`define LENET_C1_CONFIG_SVH

// input frame, one signed pixel per beat
`define IMAGE_COLS 32
`define IMAGE_ROWS 32

// square kernel side, C1 and S2 map sides
`define KERNEL 5
`define C1_SIZE 28
`define S2_SIZE 14

// data widths
`define PIX_W 8
`define HALF_W 16
`define ACC_W 24

// AXI4-Lite register map, byte addresses
`define AXI_AW 8
`define AXI_DW 32
`define REG_WEIGHT0 8'h00
`define REG_BIAS 8'h64
`define REG_CTRL 8'h80
`define REG_STATUS 8'h84

`endif
